/* filelist.f */
mpu_pkg.sv
pma_lookup.sv
mpu_ctrl.sv
mpu_top.sv
mpu_assertions.sv
tb_mpu.sv

/* mpu_assertions.sv */
// MPU protocol checks
// Concurrent assertions on the controller, attached with bind

`timescale 1ns/10ps

module mpu_assertions (
  input logic                clk,
  input logic                rst_n,
  input mpu_pkg::mpu_state_e state_q,
  input logic                core_trans_ready_o,
  input logic                bus_trans_valid_o,
  input logic                pma_err_i,
  input logic                bus_resp_valid_i,
  input logic                core_resp_valid_o,
  input mpu_pkg::core_resp_t core_resp_o
);

  // Number of failed assertions
  int unsigned fail_cnt = 0;

  // Fault status only while the error response is presented
  a_status_in_err_resp: assert property (@(posedge clk) disable iff (!rst_n)
    (core_resp_valid_o && core_resp_o.mpu_status != mpu_pkg::MPU_OK)
      |-> (state_q == mpu_pkg::MPU_ERR_RESP))
    else begin
      $error("Fault status outside the error response state");
      fail_cnt++;
    end

  // Error response needs a drained bus window
  a_no_resp_overlap: assert property (@(posedge clk) disable iff (!rst_n)
    !(bus_resp_valid_i && state_q == mpu_pkg::MPU_ERR_RESP))
    else begin
      $error("Bus response collides with an error response");
      fail_cnt++;
    end

  a_ready_only_idle: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q != mpu_pkg::MPU_IDLE) |-> !core_trans_ready_o)
    else begin
      $error("Core side accepts a request outside the idle state");
      fail_cnt++;
    end

  // Forbidden accesses never reach the bus
  a_no_fault_on_bus: assert property (@(posedge clk) disable iff (!rst_n)
    !(bus_trans_valid_o && pma_err_i))
    else begin
      $error("Forbidden request forwarded to the bus");
      fail_cnt++;
    end

endmodule

bind mpu_ctrl mpu_assertions u_mpu_assertions (
  .clk                (clk),
  .rst_n              (rst_n),
  .state_q            (state_q),
  .core_trans_ready_o (core_trans_ready_o),
  .bus_trans_valid_o  (bus_trans_valid_o),
  .pma_err_i          (pma_err_i),
  .bus_resp_valid_i   (bus_resp_valid_i),
  .core_resp_valid_o  (core_resp_valid_o),
  .core_resp_o        (core_resp_o)
);

/* mpu_ctrl.sv */
// MPU controller
// Routes allowed core requests to the bus, turns forbidden ones into
// in-order error responses and merges both response sources

`timescale 1ns/10ps

module mpu_ctrl (
  input  logic                 clk,
  input  logic                 rst_n,

  // Core request side
  input  logic                 core_trans_valid_i,
  output logic                 core_trans_ready_o,
  input  mpu_pkg::core_trans_t core_trans_i,

  // Lookup result for the current request
  input  mpu_pkg::pma_region_t pma_cfg_i,
  input  logic                 pma_err_i,

  // Bus request side
  output logic                 bus_trans_valid_o,
  input  logic                 bus_trans_ready_i,
  output mpu_pkg::bus_trans_t  bus_trans_o,

  // Bus response side
  input  logic                 bus_resp_valid_i,
  input  mpu_pkg::bus_resp_t   bus_resp_i,

  // Core response side
  output logic                 core_resp_valid_o,
  output mpu_pkg::core_resp_t  core_resp_o
);

  mpu_pkg::mpu_state_e                  state_q;
  mpu_pkg::mpu_state_e                  state_d;
  logic [mpu_pkg::OUTSTANDING_CNT_W-1:0] outstanding_q;
  logic                                  cnt_full;
  logic                                  cnt_zero;
  logic                                  bus_accept;
  logic                                  mpu_block_core;
  logic                                  mpu_block_bus;
  logic                                  mpu_err_accept;
  logic                                  mpu_err_trans_valid;
  logic                                  err_write_q;

  //////////////////////////////
  // Blocking
  //////////////////////////////

  assign cnt_full = (outstanding_q == mpu_pkg::OUTSTANDING_CNT_W'(mpu_pkg::MAX_OUTSTANDING));
  assign cnt_zero = (outstanding_q == '0);

  // Core side stalls while an error is pending or the bus window is full
  assign mpu_block_core = (state_q != mpu_pkg::MPU_IDLE) || cnt_full;

  // Forbidden requests never reach the bus
  assign mpu_block_bus = mpu_block_core || pma_err_i;

  // Forbidden requests are taken at once, allowed ones wait for the bus
  assign core_trans_ready_o = !mpu_block_core && (pma_err_i || bus_trans_ready_i);
  assign bus_trans_valid_o  = core_trans_valid_i && !mpu_block_bus;

  assign bus_accept     = bus_trans_valid_o && bus_trans_ready_i;
  assign mpu_err_accept = core_trans_valid_i && core_trans_ready_o && pma_err_i;

  //////////////////////////////
  // Bus request
  //////////////////////////////

  always_comb begin
    bus_trans_o.addr    = core_trans_i.addr;
    bus_trans_o.wdata   = core_trans_i.wdata;
    bus_trans_o.write   = core_trans_i.write;
    bus_trans_o.atomic  = core_trans_i.atomic;
    bus_trans_o.memtype = {pma_cfg_i.cacheable, pma_cfg_i.bufferable};
  end

  // Accepted bus transfers not yet answered
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding_q <= '0;
    end else begin
      case ({bus_accept, bus_resp_valid_i})
        2'b10:   outstanding_q <= outstanding_q + 1'b1;
        2'b01:   outstanding_q <= outstanding_q - 1'b1;
        default: outstanding_q <= outstanding_q;
      endcase
    end
  end

  //////////////////////////////
  // Error response FSM
  //////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      mpu_pkg::MPU_IDLE: begin
        if (mpu_err_accept) begin
          state_d = mpu_pkg::MPU_ERR_WAIT;
        end
      end
      // Earlier bus responses drain first to keep order
      mpu_pkg::MPU_ERR_WAIT: begin
        if (cnt_zero) begin
          state_d = mpu_pkg::MPU_ERR_RESP;
        end
      end
      mpu_pkg::MPU_ERR_RESP: begin
        state_d = mpu_pkg::MPU_IDLE;
      end
      default: begin
        state_d = mpu_pkg::MPU_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= mpu_pkg::MPU_IDLE;
      err_write_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // Fault kind follows the direction of the rejected request
      if (mpu_err_accept) begin
        err_write_q <= core_trans_i.write;
      end
    end
  end

  //////////////////////////////
  // Core response merge
  //////////////////////////////

  assign mpu_err_trans_valid = (state_q == mpu_pkg::MPU_ERR_RESP);

  // Both sources never overlap since ERR_RESP needs an empty bus window
  assign core_resp_valid_o = bus_resp_valid_i || mpu_err_trans_valid;

  always_comb begin
    if (mpu_err_trans_valid) begin
      core_resp_o.rdata      = '0;
      core_resp_o.err        = 1'b0;
      core_resp_o.mpu_status = err_write_q ? mpu_pkg::MPU_WR_FAULT : mpu_pkg::MPU_RE_FAULT;
    end else begin
      core_resp_o.rdata      = bus_resp_i.rdata;
      core_resp_o.err        = bus_resp_i.err;
      core_resp_o.mpu_status = mpu_pkg::MPU_OK;
    end
  end

endmodule

/* mpu_pkg.sv */
// Memory protection unit package
// Region table, transaction and response types, FSM and status encodings

package mpu_pkg;

  //////////////////////////////
  // Widths and limits
  //////////////////////////////

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // Bus transactions that may be in flight at once
  localparam int MAX_OUTSTANDING = 4;
  localparam int OUTSTANDING_CNT_W = $clog2(MAX_OUTSTANDING + 1);

  //////////////////////////////
  // PMA region table
  //////////////////////////////

  // Word addressed, range is [low, high)
  typedef struct packed {
    logic [29:0] word_addr_low;
    logic [29:0] word_addr_high;
    logic        main;
    logic        bufferable;
    logic        cacheable;
    logic        atomic;
  } pma_region_t;

  localparam int PMA_NUM_REGIONS = 3;

  // Lower index has priority where regions overlap
  localparam pma_region_t PMA_CFG [0:PMA_NUM_REGIONS-1] = '{
    // 0x0000_0000 .. 0x0001_0000, main memory
    '{word_addr_low: 30'h0000_0000, word_addr_high: 30'h0000_4000,
      main: 1'b1, bufferable: 1'b1, cacheable: 1'b1, atomic: 1'b1},
    // 0x0000_8000 .. 0x0002_0000, I/O, partly shadowed by region 0
    '{word_addr_low: 30'h0000_2000, word_addr_high: 30'h0000_8000,
      main: 1'b0, bufferable: 1'b1, cacheable: 1'b0, atomic: 1'b0},
    // 0x1000_0000 .. 0x1000_1000, peripheral I/O
    '{word_addr_low: 30'h0400_0000, word_addr_high: 30'h0400_0400,
      main: 1'b0, bufferable: 1'b0, cacheable: 1'b0, atomic: 1'b0}
  };

  // Attributes for addresses outside every region
  localparam pma_region_t PMA_R_DEFAULT = '{default: '0};

  //////////////////////////////
  // Transactions
  //////////////////////////////

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic              write;
    logic              execute;
    logic              speculative;
    logic              atomic;
    logic              misaligned;
  } core_trans_t;

  // memtype[0] bufferable, memtype[1] cacheable
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic              write;
    logic              atomic;
    logic [1:0]        memtype;
  } bus_trans_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              err;
  } bus_resp_t;

  //////////////////////////////
  // Status and state
  //////////////////////////////

  typedef enum logic [1:0] {
    MPU_OK       = 2'd0,
    MPU_RE_FAULT = 2'd1,
    MPU_WR_FAULT = 2'd2
  } mpu_status_e;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              err;
    mpu_status_e       mpu_status;
  } core_resp_t;

  // Error response sequencing
  typedef enum logic [1:0] {
    MPU_IDLE     = 2'd0,
    MPU_ERR_WAIT = 2'd1,
    MPU_ERR_RESP = 2'd2
  } mpu_state_e;

endpackage

/* mpu_top.sv */
// MPU top level
// Region lookup and controller between the core port and the bus port

`timescale 1ns/10ps

module mpu_top (
  input  logic                 clk,
  input  logic                 rst_n,

  // Core request
  input  logic                 core_trans_valid_i,
  output logic                 core_trans_ready_o,
  input  mpu_pkg::core_trans_t core_trans_i,

  // Core response, always accepted
  output logic                 core_resp_valid_o,
  output mpu_pkg::core_resp_t  core_resp_o,

  // Bus request
  output logic                 bus_trans_valid_o,
  input  logic                 bus_trans_ready_i,
  output mpu_pkg::bus_trans_t  bus_trans_o,

  // Bus response, in request order
  input  logic                 bus_resp_valid_i,
  input  mpu_pkg::bus_resp_t   bus_resp_i
);

  mpu_pkg::pma_region_t pma_cfg;
  logic                 pma_err;

  //////////////////////////////
  // Region lookup
  //////////////////////////////

  pma_lookup u_pma_lookup (
    .addr_i        (core_trans_i.addr),
    .execute_i     (core_trans_i.execute),
    .speculative_i (core_trans_i.speculative),
    .atomic_i      (core_trans_i.atomic),
    .misaligned_i  (core_trans_i.misaligned),
    .pma_cfg_o     (pma_cfg),
    .pma_err_o     (pma_err)
  );

  //////////////////////////////
  // Controller
  //////////////////////////////

  mpu_ctrl u_mpu_ctrl (
    .clk                (clk),
    .rst_n              (rst_n),
    .core_trans_valid_i (core_trans_valid_i),
    .core_trans_ready_o (core_trans_ready_o),
    .core_trans_i       (core_trans_i),
    .pma_cfg_i          (pma_cfg),
    .pma_err_i          (pma_err),
    .bus_trans_valid_o  (bus_trans_valid_o),
    .bus_trans_ready_i  (bus_trans_ready_i),
    .bus_trans_o        (bus_trans_o),
    .bus_resp_valid_i   (bus_resp_valid_i),
    .bus_resp_i         (bus_resp_i),
    .core_resp_valid_o  (core_resp_valid_o),
    .core_resp_o        (core_resp_o)
  );

endmodule

/* pma_lookup.sv */
// PMA region lookup
// Finds the attributes of the lowest-indexed region that holds the address
// and flags accesses that the region does not allow

`timescale 1ns/10ps

module pma_lookup (
  // Access to check
  input  logic [mpu_pkg::ADDR_W-1:0] addr_i,
  input  logic                       execute_i,
  input  logic                       speculative_i,
  input  logic                       atomic_i,
  input  logic                       misaligned_i,

  // Lookup result
  output mpu_pkg::pma_region_t       pma_cfg_o,
  output logic                       pma_err_o
);

  //////////////////////////////
  // Region match
  //////////////////////////////

  logic [29:0]                         word_addr;
  logic [mpu_pkg::PMA_NUM_REGIONS-1:0] region_hit;

  // Regions are defined on word boundaries
  assign word_addr = addr_i[mpu_pkg::ADDR_W-1:2];

  // One hit bit per region, bounds are inclusive low and exclusive high
  always_comb begin
    for (int i = 0; i < mpu_pkg::PMA_NUM_REGIONS; i++) begin
      region_hit[i] = (word_addr >= mpu_pkg::PMA_CFG[i].word_addr_low) &&
                      (word_addr <  mpu_pkg::PMA_CFG[i].word_addr_high);
    end
  end

  //////////////////////////////
  // Attribute selection
  //////////////////////////////

  logic found;

  // Scan from region 0 upward and keep the first hit
  always_comb begin
    found     = 1'b0;
    pma_cfg_o = mpu_pkg::PMA_R_DEFAULT;
    for (int i = 0; i < mpu_pkg::PMA_NUM_REGIONS; i++) begin
      if (region_hit[i] && !found) begin
        found     = 1'b1;
        pma_cfg_o = mpu_pkg::PMA_CFG[i];
      end
    end
  end

  //////////////////////////////
  // Access fault decision
  //////////////////////////////

  logic exec_fault;
  logic misaligned_fault;
  logic atomic_fault;

  // Instruction fetch and speculation need main memory
  assign exec_fault = (execute_i || speculative_i) && !pma_cfg_o.main;

  // I/O regions take only naturally aligned accesses
  assign misaligned_fault = misaligned_i && !pma_cfg_o.main;

  // Atomics need explicit region support
  assign atomic_fault = atomic_i && !pma_cfg_o.atomic;

  assign pma_err_o = exec_fault || misaligned_fault || atomic_fault;

endmodule

/* tb_mpu.sv */
// MPU testbench
// Directed and random core requests with a bus responder model,
// in-order response checking against a reference model

`timescale 1ns/10ps

module tb_mpu;

  localparam int CLK_HALF     = 50;
  localparam int DRIVE_DLY    = 10;
  localparam int RESET_CYCLES = 5;
  localparam int NUM_RANDOM   = 60;

  // Access flag bits {write, execute, speculative, atomic, misaligned}
  localparam logic [4:0] F_LD  = 5'b00000;
  localparam logic [4:0] F_WR  = 5'b10000;
  localparam logic [4:0] F_EX  = 5'b01000;
  localparam logic [4:0] F_SP  = 5'b00100;
  localparam logic [4:0] F_AMO = 5'b00010;
  localparam logic [4:0] F_MIS = 5'b00001;

  typedef struct packed {
    logic                fault;
    logic [1:0]          memtype;
    mpu_pkg::mpu_status_e status;
  } exp_t;

  logic                 clk;
  logic                 rst_n;
  logic                 core_trans_valid_i;
  logic                 core_trans_ready_o;
  mpu_pkg::core_trans_t core_trans_i;
  logic                 core_resp_valid_o;
  mpu_pkg::core_resp_t  core_resp_o;
  logic                 bus_trans_valid_o;
  logic                 bus_trans_ready_i;
  mpu_pkg::bus_trans_t  bus_trans_o;
  logic                 bus_resp_valid_i;
  mpu_pkg::bus_resp_t   bus_resp_i;

  integer               seed = 32'he169;
  int                   errors = 0;
  int                   checks = 0;
  int                   issued = 0;
  int                   cycle = 0;
  int                   last_due = 0;
  string                cur_name = "reset";
  mpu_pkg::core_resp_t  exp_q[$];
  string                name_q[$];
  logic [31:0]          resp_addr_q[$];
  int                   resp_due_q[$];

  mpu_top i_mpu_top (
    .clk                (clk),
    .rst_n              (rst_n),
    .core_trans_valid_i (core_trans_valid_i),
    .core_trans_ready_o (core_trans_ready_o),
    .core_trans_i       (core_trans_i),
    .core_resp_valid_o  (core_resp_valid_o),
    .core_resp_o        (core_resp_o),
    .bus_trans_valid_o  (bus_trans_valid_o),
    .bus_trans_ready_i  (bus_trans_ready_i),
    .bus_trans_o        (bus_trans_o),
    .bus_resp_valid_i   (bus_resp_valid_i),
    .bus_resp_i         (bus_resp_i)
  );

  initial clk = 1'b0;
  always #CLK_HALF clk = ~clk;

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Region table with lowest index first, unmapped gets no attributes
  function automatic exp_t ref_check(mpu_pkg::core_trans_t t);
    exp_t e;
    logic main;
    logic amo;
    logic bufferable;
    logic cacheable;
    if (t.addr < 32'h0001_0000) begin
      {main, amo, bufferable, cacheable} = 4'b1111;
    end else if (t.addr >= 32'h0000_8000 && t.addr < 32'h0002_0000) begin
      {main, amo, bufferable, cacheable} = 4'b0010;
    end else if (t.addr >= 32'h1000_0000 && t.addr < 32'h1000_1000) begin
      {main, amo, bufferable, cacheable} = 4'b0000;
    end else begin
      {main, amo, bufferable, cacheable} = 4'b0000;
    end
    e.fault = ((t.execute || t.speculative) && !main) || (t.misaligned && !main) ||
              (t.atomic && !amo);
    e.memtype = {cacheable, bufferable};
    if (!e.fault) begin
      e.status = mpu_pkg::MPU_OK;
    end else begin
      e.status = t.write ? mpu_pkg::MPU_WR_FAULT : mpu_pkg::MPU_RE_FAULT;
    end
    return e;
  endfunction

  // Bus model read data
  function automatic logic [31:0] bus_rdata(logic [31:0] addr);
    return {addr[15:0], addr[31:16]} ^ 32'h3c5a_96e1;
  endfunction

  function automatic mpu_pkg::core_resp_t expected_resp(mpu_pkg::core_trans_t t);
    exp_t                e;
    mpu_pkg::core_resp_t r;
    e = ref_check(t);
    r.rdata      = e.fault ? 32'h0 : bus_rdata(t.addr);
    r.err        = !e.fault && (t.addr > 32'h1000_0800);
    r.mpu_status = e.status;
    return r;
  endfunction

  task automatic check_value(input string test, input logic [63:0] exp,
                             input logic [63:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Mismatch %s at %0t: expected 0x%0h, actual 0x%0h", test, $time, exp, act);
    end
  endtask

  // Hold the request until accepted, then queue its expected response
  task automatic issue_req(input string name, input logic [31:0] addr,
                           input logic [4:0] flags);
    mpu_pkg::core_trans_t t;
    t.addr  = addr;
    t.wdata = ~addr;
    {t.write, t.execute, t.speculative, t.atomic, t.misaligned} = flags;
    cur_name           = name;
    core_trans_i       = t;
    core_trans_valid_i = 1'b1;
    issued++;
    @(negedge clk);
    while (!core_trans_ready_o) @(negedge clk);
    exp_q.push_back(expected_resp(t));
    name_q.push_back(name);
    @(posedge clk);
    #DRIVE_DLY;
    core_trans_valid_i = 1'b0;
  endtask

  //////////////////////////////
  // Bus responder
  //////////////////////////////

  always @(posedge clk) begin
    cycle++;
    #DRIVE_DLY;
    bus_trans_ready_i = rst_n && (($random(seed) & 3) != 0);
    bus_resp_valid_i  = 1'b0;
    if (resp_addr_q.size() > 0 && resp_due_q[0] <= cycle) begin
      bus_resp_valid_i = 1'b1;
      bus_resp_i.rdata = bus_rdata(resp_addr_q[0]);
      bus_resp_i.err   = resp_addr_q[0] > 32'h1000_0800;
      void'(resp_addr_q.pop_front());
      void'(resp_due_q.pop_front());
    end
  end

  // Bus transfer and core response checks, mid-cycle
  always @(negedge clk) begin
    exp_t e;
    int   due;
    if (rst_n && bus_trans_valid_o && bus_trans_ready_i) begin
      e = ref_check(core_trans_i);
      check_value({cur_name, "_bus_addr"}, core_trans_i.addr, bus_trans_o.addr);
      check_value({cur_name, "_bus_wdata"}, core_trans_i.wdata, bus_trans_o.wdata);
      check_value({cur_name, "_bus_flags"}, {core_trans_i.write, core_trans_i.atomic},
                  {bus_trans_o.write, bus_trans_o.atomic});
      check_value({cur_name, "_memtype"}, e.memtype, bus_trans_o.memtype);
      check_value({cur_name, "_bus_fault"}, 1'b0, e.fault);
      due = cycle + 1 + ({$random(seed)} % 3);
      if (due < last_due) due = last_due;
      last_due = due;
      resp_addr_q.push_back(bus_trans_o.addr);
      resp_due_q.push_back(due);
    end
    if (rst_n && core_resp_valid_o) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("Core response at %0t arrived with no request waiting for one", $time);
      end else begin
        check_value(name_q.pop_front(), exp_q.pop_front(), core_resp_o);
      end
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  initial begin
    logic [31:0] off;
    logic [31:0] addr;
    logic [31:0] r;
    int          sel;
    int          drain;
    rst_n              = 1'b0;
    core_trans_valid_i = 1'b0;
    core_trans_i       = '0;
    bus_trans_ready_i  = 1'b0;
    bus_resp_valid_i   = 1'b0;
    bus_resp_i         = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;

    // Quiet after reset
    repeat (5) begin
      @(negedge clk);
      check_value("idle_resp_valid", 1'b0, core_resp_valid_o);
      check_value("idle_bus_valid", 1'b0, bus_trans_valid_o);
    end
    @(posedge clk);
    #DRIVE_DLY;

    // Plain loads and stores per region
    issue_req("load_r0", 32'h0000_0100, F_LD);
    issue_req("store_r0", 32'h0000_0200, F_WR);
    issue_req("load_r1", 32'h0001_0400, F_LD);
    issue_req("store_r1", 32'h0001_8000, F_WR);
    issue_req("load_r2", 32'h1000_0010, F_LD);
    issue_req("store_r2_err", 32'h1000_0900, F_WR);
    issue_req("load_unmapped", 32'h2000_0000, F_LD);
    // Attribute faults
    issue_req("exec_r1", 32'h0001_0000, F_EX);
    issue_req("spec_r2", 32'h1000_0040, F_SP);
    issue_req("misal_unmapped_wr", 32'h3000_0004, F_MIS | F_WR);
    issue_req("exec_unmapped", 32'h4000_0000, F_EX);
    issue_req("exec_r0", 32'h0000_0400, F_EX);
    issue_req("misal_r0", 32'h0000_0800, F_MIS);
    // Atomics
    issue_req("amo_r0", 32'h0000_1000, F_AMO);
    issue_req("amo_r1", 32'h0001_2000, F_AMO);
    issue_req("amo_r2_wr", 32'h1000_0080, F_AMO | F_WR);
    // Overlap of regions 0 and 1
    issue_req("overlap_low", 32'h0000_8000, F_LD);
    issue_req("overlap_top", 32'h0000_fffc, F_WR);
    issue_req("overlap_amo", 32'h0000_c000, F_AMO);
    issue_req("r1_start", 32'h0001_0000, F_LD);

    // Random mix under bus back-pressure
    for (int i = 0; i < NUM_RANDOM; i++) begin
      sel = {$random(seed)} % 5;
      off = $random(seed) & 32'h0000_0ffc;
      r   = $random(seed);
      case (sel)
        0:       addr = 32'h0000_0000 + off;
        1:       addr = 32'h0000_f800 + off;
        2:       addr = 32'h0001_8000 + off;
        3:       addr = 32'h1000_0000 + off;
        default: addr = 32'h4000_0000 + off;
      endcase
      issue_req($sformatf("rand_%0d", i), addr,
                {r[0], r[3:1] == 0, r[6:4] == 0, r[9:7] == 0, r[12:10] == 0});
    end

    drain = 0;
    while (exp_q.size() != 0 && drain < 50) begin
      @(posedge clk);
      drain++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d requests never received a response", exp_q.size());
    end
    repeat (3) @(posedge clk);

    // Protocol assertion failures count as errors
    errors += i_mpu_top.u_mpu_ctrl.u_mpu_assertions.fail_cnt;

    $display("Errors: %0d of %0d checks", errors, checks);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // Limit grows with the number of issued requests
  initial begin
    while (cycle <= RESET_CYCLES + 200 * (issued + 1)) @(posedge clk);
    $display("Run timed out after %0d cycles with %0d requests issued", cycle, issued);
    $display("Errors: %0d of %0d checks", errors, checks);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule
